// File: src/rsb_cfg.svh
`ifndef RSB_CFG_SVH
`define RSB_CFG_SVH

////////////////////////////////////////
// Physical register file
////////////////////////////////////////

`define RSB_PREG_COUNT 64     // Busy bits in the table
`define RSB_PREG_W 6          // Index width for 64 regs

// Walk length runs 0 to 64 so one extra bit
`define RSB_WALK_LEN_W 7

////////////////////////////////////////
// Issue queue flow control
////////////////////////////////////////

`define RSB_ISSUE_CREDITS 8   // Free slots in the issue queue
`define RSB_CREDIT_W 4        // Holds 0 to 8

`endif

// File: src/rsb_pkg.sv
`include "rsb_cfg.svh"

package rsb_pkg;

    typedef logic [`RSB_PREG_W-1:0] preg_t;          // Physical register index
    typedef logic [`RSB_WALK_LEN_W-1:0] walk_len_t;  // Walk entries left
    typedef logic [`RSB_CREDIT_W-1:0] credit_t;      // Issue credits held

    // Recovery sequencing
    typedef enum logic [1:0] {
        REC_IDLE     = 2'd0,  // Normal dispatch
        REC_ROLLBACK = 2'd1,  // One cycle table clear
        REC_WALK     = 2'd2   // Replay surviving dests
    } rec_state_e;

    ////////////////////////////////////////
    // Request and packet structs
    ////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        logic  has_rd;   // Slot writes a destination
        preg_t rd;
        preg_t rs1;
        preg_t rs2;
    } disp_req_t;

    typedef struct packed {
        logic  valid;
        preg_t rd;
        preg_t rs1;
        logic  rs1_busy;  // Source not ready yet
        preg_t rs2;
        logic  rs2_busy;
    } issue_pkt_t;

    // Allocate or free write port
    typedef struct packed {
        logic  en;
        preg_t addr;
    } preg_wr_t;

    typedef struct packed {
        logic  valid;
        logic  complete;  // Already written back so stays free
        preg_t prd;
    } walk_entry_t;

    typedef struct packed {
        logic      valid;
        walk_len_t walk_len;  // Surviving dests to replay
    } flush_req_t;

endpackage

// File: src/busy_table.sv
`timescale 1ns/1ps
`include "rsb_cfg.svh"

module busy_table (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,        // Rollback wipe
    input  rsb_pkg::preg_wr_t   alloc [2],    // Dispatch dests set busy
    input  rsb_pkg::preg_wr_t   free_int,     // Int writeback clears
    input  rsb_pkg::preg_wr_t   free_mem,     // Mem writeback clears
    input  rsb_pkg::walk_entry_t walk [2],    // Walk replay sets busy
    input  rsb_pkg::preg_t      rd_addr [4],  // Source lookups
    output logic                rd_busy [4]
);

    logic [`RSB_PREG_COUNT-1:0] busy_q;    // One bit per physical reg
    logic [`RSB_PREG_COUNT-1:0] busy_nxt;

    logic alloc_hit [4];   // Same cycle allocate on this source
    logic free_hit [4];    // Same cycle free on this source

    ////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////

    // Later writes override earlier ones on the same bit
    always_comb begin
        busy_nxt = busy_q;
        for (int i = 0; i < 2; i++) begin
            if (alloc[i].en) begin
                busy_nxt[alloc[i].addr] = 1'b1;
            end
        end
        if (free_int.en) begin
            busy_nxt[free_int.addr] = 1'b0;
        end
        if (free_mem.en) begin
            busy_nxt[free_mem.addr] = 1'b0;
        end
        // Completed walk entries already wrote back
        for (int i = 0; i < 2; i++) begin
            if (walk[i].valid && !walk[i].complete) begin
                busy_nxt[walk[i].prd] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else if (clear) begin
            busy_q <= '0;          // Rollback beats every write
        end else begin
            busy_q <= busy_nxt;
        end
    end

    ////////////////////////////////////////
    // Read ports with bypass
    ////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            alloc_hit[p] = (alloc[0].en && (alloc[0].addr == rd_addr[p]))
                        || (alloc[1].en && (alloc[1].addr == rd_addr[p]));
            free_hit[p]  = (free_int.en && (free_int.addr == rd_addr[p]))
                        || (free_mem.en && (free_mem.addr == rd_addr[p]));
        end
    end

    // Allocate wins over free on reads
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (alloc_hit[p]) begin
                rd_busy[p] = 1'b1;
            end else if (free_hit[p]) begin
                rd_busy[p] = 1'b0;   // Result lands this cycle
            end else begin
                rd_busy[p] = busy_q[rd_addr[p]];
            end
        end
    end

endmodule

// File: src/walk_counter.sv
`timescale 1ns/1ps
`include "rsb_cfg.svh"

module walk_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,       // Flush taken
    input  rsb_pkg::walk_len_t load_len,
    input  logic [1:0]         dec,        // Walk entries accepted this cycle
    output rsb_pkg::walk_len_t remaining,
    output logic               last        // This decrement empties the walk
);

    rsb_pkg::walk_len_t dec_ext;

    assign dec_ext = rsb_pkg::walk_len_t'(dec);

    // Zero decrement never counts as the end
    assign last = (dec != 2'd0) && (remaining == dec_ext);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= load_len;      // Fresh walk length
        end else if (dec != 2'd0) begin
            remaining <= remaining - dec_ext;
        end
    end

endmodule

// File: src/recovery_fsm.sv
`timescale 1ns/1ps
`include "rsb_cfg.svh"

module recovery_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rsb_pkg::flush_req_t  flush,
    input  rsb_pkg::walk_entry_t walk [2],
    output logic                 clear,        // Wipe the busy table
    output logic                 walk_ready,
    output logic                 stall,        // Hold dispatch
    output rsb_pkg::walk_entry_t walk_out [2]  // Gated walk to the table
);

    rsb_pkg::rec_state_e state_q;
    rsb_pkg::rec_state_e state_nxt;

    rsb_pkg::walk_len_t remaining;
    logic               last;
    logic               load;
    logic [1:0]         walk_cnt;   // Accepted walk entries

    ////////////////////////////////////////
    // State register and next state
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rsb_pkg::REC_IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            rsb_pkg::REC_IDLE: begin
                if (flush.valid) begin
                    state_nxt = rsb_pkg::REC_ROLLBACK;
                end
            end
            // Counter already holds the flush length here
            rsb_pkg::REC_ROLLBACK: begin
                state_nxt = (remaining == '0) ? rsb_pkg::REC_IDLE : rsb_pkg::REC_WALK;
            end
            rsb_pkg::REC_WALK: begin
                if (last) begin
                    state_nxt = rsb_pkg::REC_IDLE;   // Last entries taken now
                end
            end
            default: state_nxt = rsb_pkg::REC_IDLE;
        endcase
    end

    assign clear      = (state_q == rsb_pkg::REC_ROLLBACK);
    assign walk_ready = (state_q == rsb_pkg::REC_WALK);
    assign stall      = (state_q != rsb_pkg::REC_IDLE);
    assign load       = flush.valid && (state_q == rsb_pkg::REC_IDLE);

    // Walk only reaches the table while replaying
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            walk_out[i]       = walk[i];
            walk_out[i].valid = walk[i].valid && walk_ready;
        end
    end

    assign walk_cnt = {1'b0, walk_out[0].valid} + {1'b0, walk_out[1].valid};

    walk_counter i_walk_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .load_len  (flush.walk_len),
        .dec       (walk_cnt),
        .remaining (remaining),
        .last      (last)
    );

endmodule

// File: src/dispatch_gate.sv
`timescale 1ns/1ps
`include "rsb_cfg.svh"

module dispatch_gate (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rsb_pkg::disp_req_t   disp [2],
    input  logic                 stall,          // Recovery in progress
    input  logic [1:0]           credit_return,  // Slots freed by the issue queue
    input  logic                 src_busy [4],
    output rsb_pkg::preg_wr_t    alloc [2],
    output rsb_pkg::preg_t       src_addr [4],
    output logic                 disp_ready [2],
    output rsb_pkg::issue_pkt_t  issue [2]
);

    rsb_pkg::credit_t credits_q;
    rsb_pkg::credit_t credits_nxt;
    logic [1:0]       take;    // Accepted slots

    ////////////////////////////////////////
    // In-order acceptance
    ////////////////////////////////////////

    assign take[0] = disp[0].valid && (credits_q != '0) && !stall;
    // Slot 1 only behind slot 0 and with a second credit
    assign take[1] = take[0] && disp[1].valid && (credits_q >= rsb_pkg::credit_t'(2));

    assign credits_nxt = credits_q
                       - rsb_pkg::credit_t'(take[0])
                       - rsb_pkg::credit_t'(take[1])
                       + rsb_pkg::credit_t'(credit_return);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= rsb_pkg::credit_t'(`RSB_ISSUE_CREDITS);   // Queue starts empty
        end else begin
            credits_q <= credits_nxt;
        end
    end

    // Lookups run every cycle whether or not the slot goes
    assign src_addr[0] = disp[0].rs1;
    assign src_addr[1] = disp[0].rs2;
    assign src_addr[2] = disp[1].rs1;
    assign src_addr[3] = disp[1].rs2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            disp_ready[i]     = take[i];
            alloc[i].en       = take[i] && disp[i].has_rd;   // Dest goes busy
            alloc[i].addr     = disp[i].rd;
            issue[i].valid    = take[i];
            issue[i].rd       = disp[i].rd;
            issue[i].rs1      = disp[i].rs1;
            issue[i].rs1_busy = src_busy[2*i];
            issue[i].rs2      = disp[i].rs2;
            issue[i].rs2_busy = src_busy[2*i+1];
        end
    end

endmodule

// File: src/rename_sb_top.sv
`timescale 1ns/1ps
`include "rsb_cfg.svh"

module rename_sb_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rsb_pkg::disp_req_t   disp [2],
    input  logic [1:0]           credit_return,
    input  rsb_pkg::preg_wr_t    int_free,
    input  rsb_pkg::preg_wr_t    mem_free,
    input  rsb_pkg::flush_req_t  flush,
    input  rsb_pkg::walk_entry_t walk [2],
    output logic                 disp_ready [2],
    output rsb_pkg::issue_pkt_t  issue [2],
    output logic                 walk_ready,
    output logic                 stall
);

    logic                 clear;          // Rollback pulse
    rsb_pkg::walk_entry_t walk_gated [2];
    rsb_pkg::preg_wr_t    alloc [2];
    rsb_pkg::preg_t       src_addr [4];   // rs1/rs2 of both slots
    logic                 src_busy [4];

    recovery_fsm i_recovery_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .walk       (walk),
        .clear      (clear),
        .walk_ready (walk_ready),
        .stall      (stall),
        .walk_out   (walk_gated)
    );

    dispatch_gate i_dispatch_gate (
        .clk           (clk),
        .rst_n         (rst_n),
        .disp          (disp),
        .stall         (stall),
        .credit_return (credit_return),
        .src_busy      (src_busy),
        .alloc         (alloc),
        .src_addr      (src_addr),
        .disp_ready    (disp_ready),
        .issue         (issue)
    );

    busy_table i_busy_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .alloc    (alloc),
        .free_int (int_free),
        .free_mem (mem_free),
        .walk     (walk_gated),
        .rd_addr  (src_addr),
        .rd_busy  (src_busy)
    );

endmodule

// File: sim/tb_rename_sb.sv
`timescale 1ns/1ps
`include "rsb_cfg.svh"

module tb_rename_sb;

    // Upper bound per phase for reset, fresh, bypass, credits, walk, zero walk and mix
    localparam int TEST_CYCLES   = 8 + 40 + 400 + 100 + 270 + 100 + 3400;
    localparam int MARGIN_CYCLES = 500;

    logic                 clk;
    logic                 rst_n;
    rsb_pkg::disp_req_t   disp [2];
    logic [1:0]           credit_return;
    rsb_pkg::preg_wr_t    int_free;
    rsb_pkg::preg_wr_t    mem_free;
    rsb_pkg::flush_req_t  flush;
    rsb_pkg::walk_entry_t walk [2];
    logic                 disp_ready [2];
    rsb_pkg::issue_pkt_t  issue [2];
    logic                 walk_ready;
    logic                 stall;

    logic [`RSB_PREG_COUNT-1:0] m_busy;   // Shadow busy table
    int                  m_credits;       // Credits held by the gate
    int                  m_remaining;     // Walk entries still owed
    rsb_pkg::rec_state_e m_state;         // Recovery state mirror
    int                  accepted;        // Slots taken since last cleared

    string test_name;
    bit    disp_on;     // Offer dispatch slots
    bit    rd_on;       // Slots carry a destination
    bit    free_on;     // Writeback frees
    bit    returns_on;  // Issue queue hands credits back
    int    addr_max;    // Small range forces address hits

    rename_sb_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * 40);
        fail_run("Watchdog timeout, the tests ran past their cycle budget");
    end

    ////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_issue(input string what, input rsb_pkg::issue_pkt_t exp,
                               input rsb_pkg::issue_pkt_t act);
        if (exp !== act)
            fail_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act));
    endtask

    task automatic check_ready(input string what, input logic [1:0] exp, input logic [1:0] act);
        if (exp !== act)
            fail_run($sformatf("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act));
    endtask

    // Allocate beats free, free beats the stored bit
    function automatic logic ref_busy(input rsb_pkg::preg_t addr, input rsb_pkg::preg_wr_t a0,
                                      input rsb_pkg::preg_wr_t a1);
        if ((a0.en && a0.addr == addr) || (a1.en && a1.addr == addr)) return 1'b1;
        if ((int_free.en && int_free.addr == addr) || (mem_free.en && mem_free.addr == addr))
            return 1'b0;
        return m_busy[addr];
    endfunction

    function automatic rsb_pkg::issue_pkt_t exp_issue(input rsb_pkg::disp_req_t d,
            input logic take, input rsb_pkg::preg_wr_t a0, input rsb_pkg::preg_wr_t a1);
        rsb_pkg::issue_pkt_t p;
        p.valid    = take;
        p.rd       = d.rd;
        p.rs1      = d.rs1;
        p.rs1_busy = ref_busy(d.rs1, a0, a1);
        p.rs2      = d.rs2;
        p.rs2_busy = ref_busy(d.rs2, a0, a1);
        return p;
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic rsb_pkg::preg_t rand_preg();
        return rsb_pkg::preg_t'($urandom_range(0, addr_max));
    endfunction

    // One cycle of random traffic driven 2 ns after the edge
    task automatic step();
        int left;
        int lim;
        @(posedge clk);
        #2;
        left = m_remaining;
        lim  = (`RSB_ISSUE_CREDITS - m_credits < 2) ? `RSB_ISSUE_CREDITS - m_credits : 2;
        for (int i = 0; i < 2; i++) begin
            disp[i].valid  = disp_on && ($urandom_range(0, 3) != 0);
            disp[i].has_rd = rd_on && ($urandom_range(0, 2) != 0);
            disp[i].rd     = rand_preg();
            disp[i].rs1    = rand_preg();
            disp[i].rs2    = rand_preg();
            // Ignored outside walk and never more than owed in walk
            walk[i].valid  = ((m_state != rsb_pkg::REC_WALK) || (left > 0))
                          && ($urandom_range(0, 2) != 0);
            walk[i].complete = $urandom_range(0, 1) != 0;
            walk[i].prd      = rand_preg();
            left -= int'(walk[i].valid);
        end
        if ($urandom_range(0, 1) != 0) disp[1].rs1 = disp[0].rd;   // Dependent second slot
        int_free = '{en: free_on && ($urandom_range(0, 2) == 0), addr: rand_preg()};
        mem_free = '{en: free_on && ($urandom_range(0, 2) == 0), addr: rand_preg()};
        credit_return = returns_on ? 2'($urandom_range(0, lim)) : 2'd0;
        flush = '0;
    endtask

    task automatic run(input int n);
        repeat (n) step();
    endtask

    // Every register looked up once without allocates
    task automatic probe_all();
        for (int k = 0; k < `RSB_PREG_COUNT / 4; k++) begin
            step();
            disp[0].has_rd = 1'b0;
            disp[1].has_rd = 1'b0;
            disp[0].rs1    = rsb_pkg::preg_t'(4 * k);
            disp[0].rs2    = rsb_pkg::preg_t'(4 * k + 1);
            disp[1].rs1    = rsb_pkg::preg_t'(4 * k + 2);
            disp[1].rs2    = rsb_pkg::preg_t'(4 * k + 3);
        end
    endtask

    task automatic flush_and_walk(input int len);
        int stall_cyc;
        int walk_cyc;
        stall_cyc = 0;
        walk_cyc  = 0;
        do step(); while (m_state != rsb_pkg::REC_IDLE);
        flush = '{valid: 1'b1, walk_len: rsb_pkg::walk_len_t'(len)};
        do begin
            step();
            stall_cyc += int'(stall);
            walk_cyc  += int'(walk_ready);
            if (stall_cyc > 200) fail_run("Stall stayed high for 200 cycles after a flush");
        end while (stall);
        // One rollback cycle plus the replay
        if (stall_cyc != 1 + walk_cyc)
            fail_run($sformatf("Flush of %0d entries stalled %0d cycles for %0d walk cycles",
                               len, stall_cyc, walk_cyc));
    endtask

    ////////////////////////////////////////
    // Compare process and shadow update
    ////////////////////////////////////////

    initial begin : compare
        rsb_pkg::preg_wr_t a0;
        rsb_pkg::preg_wr_t a1;
        logic              take0;
        logic              take1;
        int                n;
        forever begin
            @(posedge clk);
            #10;
            take0 = disp[0].valid && (m_credits != 0) && (m_state == rsb_pkg::REC_IDLE);
            take1 = take0 && disp[1].valid && (m_credits >= 2);
            a0 = '{en: take0 && disp[0].has_rd, addr: disp[0].rd};
            a1 = '{en: take1 && disp[1].has_rd, addr: disp[1].rd};
            check_flag("stall", m_state != rsb_pkg::REC_IDLE, stall);
            check_flag("walk_ready", m_state == rsb_pkg::REC_WALK, walk_ready);
            if (disp_ready[1] && !disp_ready[0]) fail_run("Slot 1 was accepted without slot 0");
            check_ready("disp_ready", {take1, take0}, {disp_ready[1], disp_ready[0]});
            check_issue("issue0", exp_issue(disp[0], take0, a0, a1), issue[0]);
            check_issue("issue1", exp_issue(disp[1], take1, a0, a1), issue[1]);
            if (rst_n) begin
                accepted  += int'(disp_ready[0]) + int'(disp_ready[1]);
                m_credits += int'(credit_return) - int'(take0) - int'(take1);
                n = 0;
                if (m_state == rsb_pkg::REC_ROLLBACK) begin
                    m_busy = '0;                   // Clear wins over all writes
                end else begin
                    if (a0.en) m_busy[a0.addr] = 1'b1;
                    if (a1.en) m_busy[a1.addr] = 1'b1;
                    if (int_free.en) m_busy[int_free.addr] = 1'b0;
                    if (mem_free.en) m_busy[mem_free.addr] = 1'b0;
                    for (int i = 0; i < 2; i++) begin
                        if (m_state == rsb_pkg::REC_WALK && walk[i].valid) begin
                            n++;
                            if (!walk[i].complete) m_busy[walk[i].prd] = 1'b1;
                        end
                    end
                end
                case (m_state)
                    rsb_pkg::REC_IDLE: begin
                        if (flush.valid) begin
                            m_state     = rsb_pkg::REC_ROLLBACK;
                            m_remaining = int'(flush.walk_len);
                        end
                    end
                    rsb_pkg::REC_ROLLBACK: begin
                        m_state = (m_remaining == 0) ? rsb_pkg::REC_IDLE : rsb_pkg::REC_WALK;
                    end
                    default: begin
                        if (n != 0 && n == m_remaining) m_state = rsb_pkg::REC_IDLE;
                        m_remaining -= n;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        rst_n         = 1'b0;
        disp[0]       = '0;
        disp[1]       = '0;
        walk[0]       = '0;
        walk[1]       = '0;
        credit_return = '0;
        int_free      = '0;
        mem_free      = '0;
        flush         = '0;
        m_busy        = '0;
        m_credits     = `RSB_ISSUE_CREDITS;
        m_remaining   = 0;
        m_state       = rsb_pkg::REC_IDLE;
        accepted      = 0;
        disp_on       = 1'b1;
        rd_on         = 1'b0;
        free_on       = 1'b0;
        returns_on    = 1'b1;
        addr_max      = `RSB_PREG_COUNT - 1;
        test_name     = "reset_state";
        void'($urandom(32'h072f_d722));
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        probe_all();                 // No destinations so all sources free
        test_name = "busy_bypass";
        rd_on     = 1'b1;
        free_on   = 1'b1;
        addr_max  = 15;
        run(400);
        test_name = "credit_flow";
        addr_max  = `RSB_PREG_COUNT - 1;
        disp_on   = 1'b0;
        do step(); while (m_credits != `RSB_ISSUE_CREDITS);   // Drain the issue queue
        returns_on = 1'b0;
        disp_on    = 1'b1;
        accepted   = 0;
        run(30);
        returns_on = 1'b1;
        step();
        if (accepted != `RSB_ISSUE_CREDITS)
            fail_run($sformatf("ERROR %s accepted slots: expected %0d, actual %0d",
                               test_name, `RSB_ISSUE_CREDITS, accepted));
        run(40);
        test_name = "flush_walk";
        free_on   = 1'b0;
        repeat (3) begin
            rd_on = 1'b1;
            run(30);                 // Fill the table before wiping it
            rd_on = 1'b0;
            flush_and_walk($urandom_range(1, 20));
            probe_all();
        end
        test_name = "flush_zero";
        repeat (2) begin
            rd_on = 1'b1;
            run(30);
            rd_on = 1'b0;
            flush_and_walk(0);
            probe_all();
        end
        test_name = "random_mix";
        rd_on     = 1'b1;
        free_on   = 1'b1;
        repeat (20) begin
            run($urandom_range(50, 100));
            flush_and_walk($urandom_range(0, `RSB_PREG_COUNT));
        end
        run(50);
        #20;                         // Let the last compare finish
        if (m_state == rsb_pkg::REC_IDLE && stall === 1'b0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run("Run ended with recovery still active");
        end
    end

endmodule

// File: sources.f
+incdir+src
src/rsb_pkg.sv
src/busy_table.sv
src/walk_counter.sv
src/recovery_fsm.sv
src/dispatch_gate.sv
src/rename_sb_top.sv
sim/tb_rename_sb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rename scoreboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_rename_sb -o tb_rename_sb

# Output kept in a variable, grep decides the result
out=$(./obj_dir/tb_rename_sb || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q 'All tests passed!'; then
    exit 0
fi
exit 1
